// ==== rtl/des_pkg.sv ====
`default_nettype none

package des_pkg;

  // -------------------------------------------------------------------
  // widths and types
  // -------------------------------------------------------------------

  // length of one key half and of its rotation
  localparam int DES_HALF_KEY_BITS = 28;

  typedef logic [63:0] des_block_t;
  typedef logic [31:0] des_half_t;
  typedef logic [63:0] des_key_t;

  // C in the upper half, D in the lower half
  typedef logic [2*DES_HALF_KEY_BITS-1:0] des_cd_t;

  typedef logic [47:0] des_subkey_t;
  typedef logic [47:0] des_exp_t;
  typedef logic [4:0]  des_shift_t;
  typedef logic [3:0]  des_nibble_t;

  // -------------------------------------------------------------------
  // bit position lists, numbered from the msb at 1
  // -------------------------------------------------------------------

  // key permutation, 64 to 56, parity bits dropped
  localparam int des_pc1_tab [0:55] = '{
    57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
    10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
    63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
    14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
  };

  // compression permutation, 56 to 48
  localparam int des_pc2_tab [0:47] = '{
    14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
    23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
    41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
    44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
  };

  // expansion, 32 to 48
  localparam int des_e_tab [0:47] = '{
    32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
     8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
    16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
    24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
  };

  // p permutation after the s-boxes
  localparam int des_p_tab [0:31] = '{
    16,  7, 20, 21, 29, 12, 28, 17,
     1, 15, 23, 26,  5, 18, 31, 10,
     2,  8, 24, 14, 32, 27,  3,  9,
    19, 13, 30,  6, 22, 11,  4, 25
  };

  // -------------------------------------------------------------------
  // s-boxes
  // -------------------------------------------------------------------

  // entry 0 is box 1; each box indexed straight by its 6-bit group,
  // so rows 0/1 and rows 2/3 of the textbook table come interleaved
  localparam des_nibble_t des_sbox_tab [0:7][0:63] = '{
    // box 1
    '{4'he, 4'h0, 4'h4, 4'hf, 4'hd, 4'h7, 4'h1, 4'h4,
      4'h2, 4'he, 4'hf, 4'h2, 4'hb, 4'hd, 4'h8, 4'h1,
      4'h3, 4'ha, 4'ha, 4'h6, 4'h6, 4'hc, 4'hc, 4'hb,
      4'h5, 4'h9, 4'h9, 4'h5, 4'h0, 4'h3, 4'h7, 4'h8,
      4'h4, 4'hf, 4'h1, 4'hc, 4'he, 4'h8, 4'h8, 4'h2,
      4'hd, 4'h4, 4'h6, 4'h9, 4'h2, 4'h1, 4'hb, 4'h7,
      4'hf, 4'h5, 4'hc, 4'hb, 4'h9, 4'h3, 4'h7, 4'he,
      4'h3, 4'ha, 4'ha, 4'h0, 4'h5, 4'h6, 4'h0, 4'hd},
    // box 2
    '{4'hf, 4'h3, 4'h1, 4'hd, 4'h8, 4'h4, 4'he, 4'h7,
      4'h6, 4'hf, 4'hb, 4'h2, 4'h3, 4'h8, 4'h4, 4'he,
      4'h9, 4'hc, 4'h7, 4'h0, 4'h2, 4'h1, 4'hd, 4'ha,
      4'hc, 4'h6, 4'h0, 4'h9, 4'h5, 4'hb, 4'ha, 4'h5,
      4'h0, 4'hd, 4'he, 4'h8, 4'h7, 4'ha, 4'hb, 4'h1,
      4'ha, 4'h3, 4'h4, 4'hf, 4'hd, 4'h4, 4'h1, 4'h2,
      4'h5, 4'hb, 4'h8, 4'h6, 4'hc, 4'h7, 4'h6, 4'hc,
      4'h9, 4'h0, 4'h3, 4'h5, 4'h2, 4'he, 4'hf, 4'h9},
    // box 3
    '{4'ha, 4'hd, 4'h0, 4'h7, 4'h9, 4'h0, 4'he, 4'h9,
      4'h6, 4'h3, 4'h3, 4'h4, 4'hf, 4'h6, 4'h5, 4'ha,
      4'h1, 4'h2, 4'hd, 4'h8, 4'hc, 4'h5, 4'h7, 4'he,
      4'hb, 4'hc, 4'h4, 4'hb, 4'h2, 4'hf, 4'h8, 4'h1,
      4'hd, 4'h1, 4'h6, 4'ha, 4'h4, 4'hd, 4'h9, 4'h0,
      4'h8, 4'h6, 4'hf, 4'h9, 4'h3, 4'h8, 4'h0, 4'h7,
      4'hb, 4'h4, 4'h1, 4'hf, 4'h2, 4'he, 4'hc, 4'h3,
      4'h5, 4'hb, 4'ha, 4'h5, 4'he, 4'h2, 4'h7, 4'hc},
    // box 4
    '{4'h7, 4'hd, 4'hd, 4'h8, 4'he, 4'hb, 4'h3, 4'h5,
      4'h0, 4'h6, 4'h6, 4'hf, 4'h9, 4'h0, 4'ha, 4'h3,
      4'h1, 4'h4, 4'h2, 4'h7, 4'h8, 4'h2, 4'h5, 4'hc,
      4'hb, 4'h1, 4'hc, 4'ha, 4'h4, 4'he, 4'hf, 4'h9,
      4'ha, 4'h3, 4'h6, 4'hf, 4'h9, 4'h0, 4'h0, 4'h6,
      4'hc, 4'ha, 4'hb, 4'h1, 4'h7, 4'hd, 4'hd, 4'h8,
      4'hf, 4'h9, 4'h1, 4'h4, 4'h3, 4'h5, 4'he, 4'hb,
      4'h5, 4'hc, 4'h2, 4'h7, 4'h8, 4'h2, 4'h4, 4'he},
    // box 5
    '{4'h2, 4'he, 4'hc, 4'hb, 4'h4, 4'h2, 4'h1, 4'hc,
      4'h7, 4'h4, 4'ha, 4'h7, 4'hb, 4'hd, 4'h6, 4'h1,
      4'h8, 4'h5, 4'h5, 4'h0, 4'h3, 4'hf, 4'hf, 4'ha,
      4'hd, 4'h3, 4'h0, 4'h9, 4'he, 4'h8, 4'h9, 4'h6,
      4'h4, 4'hb, 4'h2, 4'h8, 4'h1, 4'hc, 4'hb, 4'h7,
      4'ha, 4'h1, 4'hd, 4'he, 4'h7, 4'h2, 4'h8, 4'hd,
      4'hf, 4'h6, 4'h9, 4'hf, 4'hc, 4'h0, 4'h5, 4'h9,
      4'h6, 4'ha, 4'h3, 4'h4, 4'h0, 4'h5, 4'he, 4'h3},
    // box 6
    '{4'hc, 4'ha, 4'h1, 4'hf, 4'ha, 4'h4, 4'hf, 4'h2,
      4'h9, 4'h7, 4'h2, 4'hc, 4'h6, 4'h9, 4'h8, 4'h5,
      4'h0, 4'h6, 4'hd, 4'h1, 4'h3, 4'hd, 4'h4, 4'he,
      4'he, 4'h0, 4'h7, 4'hb, 4'h5, 4'h3, 4'hb, 4'h8,
      4'h9, 4'h4, 4'he, 4'h3, 4'hf, 4'h2, 4'h5, 4'hc,
      4'h2, 4'h9, 4'h8, 4'h5, 4'hc, 4'hf, 4'h3, 4'ha,
      4'h7, 4'hb, 4'h0, 4'he, 4'h4, 4'h1, 4'ha, 4'h7,
      4'h1, 4'h6, 4'hd, 4'h0, 4'hb, 4'h8, 4'h6, 4'hd},
    // box 7
    '{4'h4, 4'hd, 4'hb, 4'h0, 4'h2, 4'hb, 4'he, 4'h7,
      4'hf, 4'h4, 4'h0, 4'h9, 4'h8, 4'h1, 4'hd, 4'ha,
      4'h3, 4'he, 4'hc, 4'h3, 4'h9, 4'h5, 4'h7, 4'hc,
      4'h5, 4'h2, 4'ha, 4'hf, 4'h6, 4'h8, 4'h1, 4'h6,
      4'h1, 4'h6, 4'h4, 4'hb, 4'hb, 4'hd, 4'hd, 4'h8,
      4'hc, 4'h1, 4'h3, 4'h4, 4'h7, 4'ha, 4'he, 4'h7,
      4'ha, 4'h9, 4'hf, 4'h5, 4'h6, 4'h0, 4'h8, 4'hf,
      4'h0, 4'he, 4'h5, 4'h2, 4'h9, 4'h3, 4'h2, 4'hc},
    // box 8
    '{4'hd, 4'h1, 4'h2, 4'hf, 4'h8, 4'hd, 4'h4, 4'h8,
      4'h6, 4'ha, 4'hf, 4'h3, 4'hb, 4'h7, 4'h1, 4'h4,
      4'ha, 4'hc, 4'h9, 4'h5, 4'h3, 4'h6, 4'he, 4'hb,
      4'h5, 4'h0, 4'h0, 4'he, 4'hc, 4'h9, 4'h7, 4'h2,
      4'h7, 4'h2, 4'hb, 4'h1, 4'h4, 4'he, 4'h1, 4'h7,
      4'h9, 4'h4, 4'hc, 4'ha, 4'he, 4'h8, 4'h2, 4'hd,
      4'h0, 4'hf, 4'h6, 4'hc, 4'ha, 4'h9, 4'hd, 4'h0,
      4'hf, 4'h3, 4'h3, 4'h5, 4'h5, 4'h6, 4'h8, 4'hb}
  };

endpackage

`default_nettype wire

// ==== rtl/des_key_sched.sv ====
`default_nettype none

module des_key_sched
  import des_pkg::*;
(
  input  des_key_t    key_in,
  input  des_shift_t  round_shift,
  output des_subkey_t subkey
);

  localparam int n_stages = $bits(des_shift_t);

  des_cd_t cd_pc1;
  des_cd_t cd_stage [0:n_stages];

  // left rotate inside one 28-bit half
  function automatic logic [DES_HALF_KEY_BITS-1:0] rotl_half(
    input logic [DES_HALF_KEY_BITS-1:0] x,
    input int                           amt
  );
    return (x << amt) | (x >> (DES_HALF_KEY_BITS - amt));
  endfunction

  // pc-1, parity bits fall out here
  always_comb
  begin
    for (int i = 0; i < 2*DES_HALF_KEY_BITS; i++)
    begin
      cd_pc1[2*DES_HALF_KEY_BITS-1-i] = key_in[64 - des_pc1_tab[i]];
    end
  end

  // log rotator, stage s moves both halves by 2**s when count bit s is set
  assign cd_stage[0] = cd_pc1;

  for (genvar s = 0; s < n_stages; s++)
  begin : g_rot
    localparam int amt = 1 << s;
    assign cd_stage[s+1] = round_shift[s] ?
      {rotl_half(cd_stage[s][2*DES_HALF_KEY_BITS-1:DES_HALF_KEY_BITS], amt),
       rotl_half(cd_stage[s][DES_HALF_KEY_BITS-1:0], amt)} :
      cd_stage[s];
  end

  // pc-2 picks 48 of the 56 rotated bits
  always_comb
  begin
    for (int i = 0; i < $bits(des_subkey_t); i++)
    begin
      subkey[$bits(des_subkey_t)-1-i] = cd_stage[n_stages][56 - des_pc2_tab[i]];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/des_sbox_layer.sv ====
`default_nettype none

module des_sbox_layer
  import des_pkg::*;
(
  input  des_exp_t  mixed,
  output des_half_t sbox_out
);

  localparam int n_boxes = 8;

  logic [5:0]  group [0:n_boxes-1];
  des_nibble_t nibble [0:n_boxes-1];

  // box 1 sees the top six bits, box 8 the bottom six
  for (genvar b = 0; b < n_boxes; b++)
  begin : g_box
    assign group[b]  = mixed[47 - 6*b -: 6];
    assign nibble[b] = des_sbox_tab[b][group[b]];
  end

  // pack with box 1 in the top nibble
  always_comb
  begin
    for (int b = 0; b < n_boxes; b++)
    begin
      sbox_out[31 - 4*b -: 4] = nibble[b];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/des_feistel_f.sv ====
`default_nettype none

module des_feistel_f
  import des_pkg::*;
(
  input  des_half_t   r_half,
  input  des_subkey_t subkey,
  output des_half_t   f_out
);

  des_exp_t  expanded;
  des_exp_t  mixed;
  des_half_t sbox_out;

  // -------------------------------------------------------------------
  // expansion and key mixing
  // -------------------------------------------------------------------

  // edge bits of each 4-bit chunk get copied into the neighbours
  always_comb
  begin
    for (int i = 0; i < $bits(des_exp_t); i++)
    begin
      expanded[$bits(des_exp_t)-1-i] = r_half[32 - des_e_tab[i]];
    end
  end

  assign mixed = expanded ^ subkey;

  // -------------------------------------------------------------------
  // substitution and p permutation
  // -------------------------------------------------------------------

  des_sbox_layer u_sbox (
    .mixed    (mixed),
    .sbox_out (sbox_out)
  );

  always_comb
  begin
    for (int i = 0; i < $bits(des_half_t); i++)
    begin
      f_out[$bits(des_half_t)-1-i] = sbox_out[32 - des_p_tab[i]];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/des_round.sv ====
`default_nettype none

module des_round
  import des_pkg::*;
(
  input  logic       hclk,
  input  logic       por_n,
  input  logic       stall,
  input  logic       decrypt,
  input  des_shift_t enc_shift,
  input  des_shift_t dec_shift,
  input  des_key_t   key_in,
  input  des_block_t din,
  output des_block_t dout
);

  des_shift_t  round_shift;
  des_subkey_t subkey;
  des_half_t   l_half;
  des_half_t   r_half;
  des_half_t   f_out;

  // cumulative count from the pc-1 result, chosen per direction
  assign round_shift = decrypt ? dec_shift : enc_shift;

  assign l_half = din[63:32];
  assign r_half = din[31:0];

  // -------------------------------------------------------------------
  // subkey and round function
  // -------------------------------------------------------------------

  des_key_sched u_key_sched (
    .key_in      (key_in),
    .round_shift (round_shift),
    .subkey      (subkey)
  );

  des_feistel_f u_feistel (
    .r_half (r_half),
    .subkey (subkey),
    .f_out  (f_out)
  );

  // -------------------------------------------------------------------
  // output register
  // -------------------------------------------------------------------

  // new left is old right, new right is old left mixed with f
  always_ff @(posedge hclk or negedge por_n)
  begin
    if (!por_n)
      dout <= '0;
    else if (!stall)
      dout <= {r_half, l_half ^ f_out};
  end

endmodule

`default_nettype wire

// ==== test/des_ref.svh ====
`ifndef DES_REF_SVH
`define DES_REF_SVH

// textbook bit lists, positions counted from the msb at 1
localparam int ref_pc1 [0:55] = '{
  57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18, 10,  2, 59, 51, 43, 35, 27, 19, 11,  3,
  60, 52, 44, 36, 63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22, 14,  6, 61, 53, 45, 37,
  29, 21, 13,  5, 28, 20, 12,  4
};

localparam int ref_pc2 [0:47] = '{
  14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10, 23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
  41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
};

localparam int ref_e [0:47] = '{
  32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,  8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
  16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
};

localparam int ref_p [0:31] = '{
  16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
   2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
};

// s-boxes by row, sixteen column nibbles per row with column 0 on top
localparam logic [63:0] ref_sbox_rows [0:7][0:3] = '{
  '{64'hE4D12FB83A6C5907, 64'h0F74E2D1A6CB9538, 64'h41E8D62BFC973A50, 64'hFC8249175B3EA06D},
  '{64'hF18E6B34972DC05A, 64'h3D47F28EC01A69B5, 64'h0E7BA4D158C6932F, 64'hD8A13F42B67C05E9},
  '{64'hA09E63F51DC7B428, 64'hD709346A285ECBF1, 64'hD6498F30B12C5AE7, 64'h1AD069874FE3B52C},
  '{64'h7DE3069A1285BC4F, 64'hD8B56F03472C1AE9, 64'hA690CB7DF13E5284, 64'h3F06A1D8945BC72E},
  '{64'h2C417AB6853FD0E9, 64'hEB2C47D150FA3986, 64'h421BAD78F9C5630E, 64'hB8C71E2D6F09A453},
  '{64'hC1AF92680D34E75B, 64'hAF427C9561DE0B38, 64'h9EF528C3704A1DB6, 64'h432C95FABE17608D},
  '{64'h4B2EF08D3C975A61, 64'hD0B7491AE35C2F86, 64'h14BDC37EAF680592, 64'h6BD814A7950FE23C},
  '{64'hD2846FB1A93E50C7, 64'h1FD8A374C56B0E92, 64'h7B419CE206ADF358, 64'h21E74A8DFC90356B}
};

// row from the outer two bits, column from the inner four
function automatic logic [3:0] ref_sbox(input int box, input logic [5:0] g);
  logic [63:0] row_word;
  int          col;
  row_word = ref_sbox_rows[box][{g[5], g[0]}];
  col = g[4:1];
  return row_word[63 - 4*col -: 4];
endfunction

function automatic logic [47:0] ref_subkey(input logic [63:0] key, input logic [4:0] shift);
  logic [55:0] cd;
  logic [27:0] c;
  logic [27:0] d;
  logic [47:0] k;
  int          sh;
  for (int i = 0; i < 56; i++)
    cd[55-i] = key[64 - ref_pc1[i]];
  c = cd[55:28];
  d = cd[27:0];
  sh = shift;
  // one place at a time, count taken modulo 28
  for (int n = 0; n < sh % 28; n++)
  begin
    c = {c[26:0], c[27]};
    d = {d[26:0], d[27]};
  end
  cd = {c, d};
  for (int i = 0; i < 48; i++)
    k[47-i] = cd[56 - ref_pc2[i]];
  return k;
endfunction

function automatic logic [31:0] ref_feistel(input logic [31:0] r, input logic [47:0] k);
  logic [47:0] x;
  logic [31:0] s;
  logic [31:0] f;
  for (int i = 0; i < 48; i++)
    x[47-i] = r[32 - ref_e[i]];
  x = x ^ k;
  for (int b = 0; b < 8; b++)
    s[31 - 4*b -: 4] = ref_sbox(b, x[47 - 6*b -: 6]);
  for (int i = 0; i < 32; i++)
    f[31-i] = s[32 - ref_p[i]];
  return f;
endfunction

// expected register value: right half moves up, left half mixed with f
function automatic logic [63:0] ref_round(input logic [63:0] blk, input logic [63:0] key,
                                          input logic [4:0] shift);
  return {blk[31:0], blk[63:32] ^ ref_feistel(blk[31:0], ref_subkey(key, shift))};
endfunction

`endif

// ==== test/tb_des_round.sv ====
`default_nettype none

module tb_des_round
  import des_pkg::*;
();

  localparam int clk_period = 4;
  localparam int n_enc      = 300;
  localparam int n_dec      = 200;
  localparam int n_stall    = 8;
  localparam int n_vectors  = n_enc + n_dec + n_stall + 2*16 + 12;
  localparam int timeout    = (n_vectors + 100) * clk_period;

  // cumulative rotate counts of the standard schedule
  localparam des_shift_t enc_counts [0:15] = '{
    5'd1, 5'd2, 5'd4, 5'd6, 5'd8, 5'd10, 5'd12, 5'd14,
    5'd15, 5'd17, 5'd19, 5'd21, 5'd23, 5'd25, 5'd27, 5'd28
  };
  localparam des_shift_t dec_counts [0:15] = '{
    5'd28, 5'd27, 5'd25, 5'd23, 5'd21, 5'd19, 5'd17, 5'd15,
    5'd14, 5'd12, 5'd10, 5'd8, 5'd6, 5'd4, 5'd2, 5'd1
  };

  logic       hclk = 1'b0;
  logic       por_n;
  logic       stall;
  logic       decrypt;
  des_shift_t enc_shift;
  des_shift_t dec_shift;
  des_key_t   key_in;
  des_block_t din;
  des_block_t dout;

  des_block_t  exp_dout;
  des_half_t   exp_upper;
  logic [31:0] rng_state = 32'h7502_3cd7;

  `include "des_ref.svh"

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic [63:0] rand64();
    logic [63:0] v;
    v[63:32] = next_rand();
    v[31:0]  = next_rand();
    return v;
  endfunction

  function automatic des_shift_t rand_shift();
    return des_shift_t'(next_rand() >> 27);
  endfunction

  always #(clk_period/2) hclk = ~hclk;

  des_round u_des_round (
    .hclk      (hclk),
    .por_n     (por_n),
    .stall     (stall),
    .decrypt   (decrypt),
    .enc_shift (enc_shift),
    .dec_shift (dec_shift),
    .key_in    (key_in),
    .din       (din),
    .dout      (dout)
  );

  // -------------------------------------------------------------------
  // checks
  // -------------------------------------------------------------------

  task automatic report_fail();
    $display("Some tests failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_block(input des_block_t got, input des_block_t exp, input string what);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
      report_fail();
    end
  endtask

  task automatic check_half(input des_half_t got, input des_half_t exp, input string what);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
      report_fail();
    end
  endtask

  // expected dout, loaded from the inputs of each non-stalled edge
  always @(posedge hclk or negedge por_n)
  begin
    if (!por_n)
    begin
      exp_dout  <= '0;
      exp_upper <= '0;
    end
    else if (!stall)
    begin
      exp_dout  <= ref_round(din, key_in, decrypt ? dec_shift : enc_shift);
      exp_upper <= din[31:0];
    end
  end

  always @(negedge hclk)
  begin
    check_half(dout[63:32], exp_upper, "upper half of dout");
    check_block(dout, exp_dout, "round output");
  end

  initial
  begin
    #(timeout);
    $display("the run timed out after %0d time units without finishing", timeout);
    report_fail();
  end

  // -------------------------------------------------------------------
  // stimulus
  // -------------------------------------------------------------------

  task automatic next_cycle();
    @(posedge hclk);
    #1;
  endtask

  task automatic drive_random(input logic mode);
    decrypt   = mode;
    din       = rand64();
    key_in    = rand64();
    dec_shift = rand_shift();
    // decryption vectors always get a different encryption count
    if (mode)
      enc_shift = dec_shift ^ (rand_shift() | 5'd1);
    else
      enc_shift = rand_shift();
  endtask

  initial
  begin : stimulus
    des_block_t start;
    des_block_t cur;
    des_block_t held;
    por_n     = 1'b0;
    stall     = 1'b1;
    decrypt   = 1'b0;
    enc_shift = '0;
    dec_shift = '0;
    key_in    = '0;
    din       = '0;
    repeat (3) @(posedge hclk);
    #1;
    por_n = 1'b1;
    drive_random(1'b0);
    // still stalled, so the reset value must stay
    next_cycle();
    check_block(dout, '0, "dout after reset release");
    next_cycle();
    check_block(dout, '0, "dout before first enabled edge");
    stall = 1'b0;

    repeat (n_enc)
    begin
      drive_random(1'b0);
      next_cycle();
    end
    repeat (n_dec)
    begin
      drive_random(1'b1);
      next_cycle();
    end

    // hold under stall while the inputs keep moving
    drive_random(1'b0);
    next_cycle();
    held  = exp_dout;
    stall = 1'b1;
    repeat (n_stall)
    begin
      drive_random(1'(next_rand() >> 31));
      next_cycle();
      check_block(dout, held, "stalled dout");
    end
    stall = 1'b0;
    drive_random(1'b1);
    next_cycle();

    // sixteen rounds forward, swap, sixteen rounds back, swap
    start  = rand64();
    key_in = rand64();
    cur    = start;
    for (int i = 0; i < 16; i++)
    begin
      decrypt   = 1'b0;
      din       = cur;
      enc_shift = enc_counts[i];
      dec_shift = rand_shift();
      next_cycle();
      cur = dout;
    end
    cur = {cur[31:0], cur[63:32]};
    for (int i = 0; i < 16; i++)
    begin
      decrypt   = 1'b1;
      din       = cur;
      dec_shift = dec_counts[i];
      enc_shift = rand_shift();
      next_cycle();
      cur = dout;
    end
    cur = {cur[31:0], cur[63:32]};
    check_block(cur, start, "round trip result");

    @(negedge hclk);
    #1;
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+test
rtl/des_pkg.sv
rtl/des_key_sched.sv
rtl/des_sbox_layer.sv
rtl/des_feistel_f.sv
rtl/des_round.sv
test/tb_des_round.sv
